/* sources.f */
+incdir+hw
hw/soc_bus_pkg.sv
hw/soc_dbg_pkg.sv
hw/soc_boot_rom.sv
hw/soc_ram.sv
hw/soc_bus_router.sv
hw/soc_reset_debug_ctrl.sv
hw/soc_harness_top.sv
sim/tb_soc_harness.sv

/* run_sim.sh */
#!/bin/sh
# Builds the harness and its testbench with Verilator, then runs the simulation.
# A failing check ends the run in $fatal, so the exit status carries the result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  -f sources.f \
  --top-module tb_soc_harness \
  --Mdir obj_dir \
  -o tb_soc_harness

./obj_dir/tb_soc_harness

/* sim/tb_soc_harness.sv */
// Self-checking testbench for the harness top with bus, reset and debug reference models
// Fixed LFSR seed; every tracked RAM word is fully written before any partial write
`timescale 1ns/1ps
`default_nettype none

`include "soc_macros.svh"

module tb_soc_harness import soc_bus_pkg::*, soc_dbg_pkg::*; ();

  localparam int unsigned clk_period     = 40;
  localparam int unsigned ram_idx_w      = $clog2(`SOC_RAM_WORDS);
  localparam int unsigned rom_idx_w      = $clog2(`SOC_ROM_WORDS);
  localparam int unsigned gpio_idx_w     = $clog2(`SOC_GPIO_LEN / `SOC_BE_W);
  localparam int unsigned num_words      = 16;
  localparam int unsigned num_rand_wr    = 48;
  localparam int unsigned num_rom        = 32;
  localparam int unsigned num_gpio       = 8;
  localparam int unsigned num_unmapped   = 6;
  localparam int unsigned num_rom_wr     = 8;
  localparam int unsigned num_b2b        = 24;
  localparam int unsigned num_ndm        = 4;
  localparam int unsigned total_req      = 3 * num_words + num_rand_wr + num_rom + num_gpio +
                                           num_unmapped + 2 * num_rom_wr + num_b2b + num_ndm;
  localparam int unsigned timeout_cycles = total_req + `SOC_DBG_DELAY + 200;

  // Just outside each window, plus both ends of the address space
  localparam logic [`SOC_ADDR_W-1:0] unmapped [num_unmapped] = '{
    32'h0000_0000, 32'h0000_fff8, 32'h0001_1000,
    32'h4000_1000, 32'h8000_2000, 32'hffff_fff8
  };

  logic      clk;
  logic      rst_n;
  logic      ndmreset;
  bus_req_t  bus_req;
  bus_rsp_t  bus_rsp;
  logic      dbg_jtag_req;
  logic      dbg_dmi_req;
  dbg_ctrl_t dbg_ctrl;
  logic      core_rst_n;
  logic      dbg_req_core;

  logic [31:0]            lfsr_state = 32'ha36bfa62;
  logic [`SOC_DATA_W-1:0] shadow [`SOC_RAM_WORDS];
  logic [ram_idx_w-1:0]   words [num_words];
  logic [rom_idx_w-1:0]   rom_idx [num_rom_wr];
  bus_rsp_t               exp_q [$];
  int unsigned            due_q [$];
  int unsigned            cyc = 0;
  int unsigned            holdoff_left = `SOC_DBG_DELAY;
  int unsigned            rel_edges = 0;

  soc_harness_top DUT (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .ndmreset_i     ( ndmreset     ),
    .bus_req_i      ( bus_req      ),
    .bus_rsp_o      ( bus_rsp      ),
    .dbg_jtag_req_i ( dbg_jtag_req ),
    .dbg_dmi_req_i  ( dbg_dmi_req  ),
    .dbg_ctrl_i     ( dbg_ctrl     ),
    .core_rst_no    ( core_rst_n   ),
    .dbg_req_core_o ( dbg_req_core )
  );

  always #(clk_period / 2) clk = ~clk;

  // ------------------------------
  // Random source
  // ------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // ------------------------------
  // Reference models
  // ------------------------------
  function automatic logic [`SOC_DATA_W-1:0] rom_word(input int unsigned idx);
    return {32'(idx), ~32'(idx)};
  endfunction

  function automatic logic [`SOC_DATA_W-1:0] be_merge(input logic [`SOC_DATA_W-1:0] old_w,
                                                       input logic [`SOC_DATA_W-1:0] new_w,
                                                       input logic [`SOC_BE_W-1:0] be);
    logic [`SOC_DATA_W-1:0] m;
    m = old_w;
    for (int b = 0; b < `SOC_BE_W; b++) begin
      if (be[b]) begin
        m[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return m;
  endfunction

  function automatic region_e region_of(input logic [`SOC_ADDR_W-1:0] addr);
    if (addr >= `SOC_ROM_BASE && addr < `SOC_ROM_BASE + `SOC_ROM_WORDS * `SOC_BE_W) begin
      return REGION_ROM;
    end
    if (addr >= `SOC_RAM_BASE && addr < `SOC_RAM_BASE + `SOC_RAM_WORDS * `SOC_BE_W) begin
      return REGION_RAM;
    end
    if (addr >= `SOC_GPIO_BASE && addr < `SOC_GPIO_BASE + `SOC_GPIO_LEN) begin
      return REGION_GPIO;
    end
    return REGION_NONE;
  endfunction

  // Expected response; RAM writes also update the shadow copy
  function automatic bus_rsp_t predict_rsp(input logic we, input logic [`SOC_ADDR_W-1:0] addr,
                                           input logic [`SOC_BE_W-1:0] be,
                                           input logic [`SOC_DATA_W-1:0] wdata);
    bus_rsp_t    rsp;
    int unsigned idx;
    rsp        = '0;
    rsp.rvalid = 1'b1;
    case (region_of(addr))
      REGION_ROM: begin
        idx = (addr - `SOC_ROM_BASE) / `SOC_BE_W;
        if (we) begin
          rsp.err = 1'b1;
        end else begin
          rsp.rdata = rom_word(idx);
        end
      end
      REGION_RAM: begin
        idx = (addr - `SOC_RAM_BASE) / `SOC_BE_W;
        if (we) begin
          shadow[idx] = be_merge(shadow[idx], wdata, be);
        end else begin
          rsp.rdata = shadow[idx];
        end
      end
      default: rsp.err = 1'b1;
    endcase
    return rsp;
  endfunction

  function automatic logic dbg_expect(input int unsigned left, input dbg_ctrl_t ctrl,
                                      input logic jtag, input logic dmi);
    if (left != 0 || !ctrl.en) begin
      return 1'b0;
    end
    return (ctrl.src == DBG_SRC_JTAG) ? jtag : dmi;
  endfunction

  function automatic logic [`SOC_ADDR_W-1:0] ram_addr(input int unsigned idx);
    return `SOC_RAM_BASE + idx * `SOC_BE_W;
  endfunction

  function automatic logic [`SOC_ADDR_W-1:0] rom_addr(input int unsigned idx);
    return `SOC_ROM_BASE + idx * `SOC_BE_W;
  endfunction

  // ------------------------------
  // Checks
  // ------------------------------
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_rsp(input bus_rsp_t exp, input bus_rsp_t act);
    if (act !== exp) begin
      report_failure($sformatf(
        "ERROR at %0t: bus_rsp_o expected rvalid=%b err=%b rdata=%h, got rvalid=%b err=%b rdata=%h",
        $time, exp.rvalid, exp.err, exp.rdata, act.rvalid, act.err, act.rdata));
    end
  endtask

  task automatic check_dbg_req(input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("ERROR at %0t: dbg_req_core_o expected %b, got %b",
                               $time, exp, act));
    end
  endtask

  task automatic check_core_rst(input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("ERROR at %0t: core_rst_no expected %b, got %b",
                               $time, exp, act));
    end
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic bus_access(input logic we, input logic [`SOC_ADDR_W-1:0] addr,
                            input logic [`SOC_BE_W-1:0] be,
                            input logic [`SOC_DATA_W-1:0] wdata, input bit expect_rsp);
    @(posedge clk);
    #2;
    bus_req.req   = 1'b1;
    bus_req.we    = we;
    bus_req.addr  = addr;
    bus_req.be    = be;
    bus_req.wdata = wdata;
    if (expect_rsp) begin
      exp_q.push_back(predict_rsp(we, addr, be, wdata));
      due_q.push_back(cyc + 1);
    end
  endtask

  task automatic bus_idle();
    @(posedge clk);
    #2;
    bus_req.req = 1'b0;
  endtask

  task automatic drive_dbg(input logic en, input logic src_jtag, input logic jtag,
                           input logic dmi);
    @(posedge clk);
    #2;
    dbg_ctrl.en  = en;
    dbg_ctrl.src = src_jtag ? DBG_SRC_JTAG : DBG_SRC_DMI;
    dbg_jtag_req = jtag;
    dbg_dmi_req  = dmi;
  endtask

  task automatic drive_ndmreset(input logic level);
    @(posedge clk);
    #2;
    ndmreset    = level;
    bus_req.req = 1'b0;
  endtask

  // Cycle count with models of the hold-off counter and the reset release
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (!rst_n) begin
      holdoff_left <= `SOC_DBG_DELAY;
    end else if (holdoff_left != 0) begin
      holdoff_left <= holdoff_left - 1;
    end
    if (!rst_n || ndmreset) begin
      rel_edges <= 0;
    end else if (rel_edges < 2) begin
      rel_edges <= rel_edges + 1;
    end
  end

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    check_core_rst(rst_n && !ndmreset && rel_edges >= 2, core_rst_n);
    check_dbg_req(dbg_expect(holdoff_left, dbg_ctrl, dbg_jtag_req, dbg_dmi_req), dbg_req_core);
    if (due_q.size() != 0 && due_q[0] == cyc) begin
      check_rsp(exp_q[0], bus_rsp);
      exp_q.delete(0);
      due_q.delete(0);
    end else if (bus_rsp.rvalid !== 1'b0) begin
      report_failure("A bus response appeared with no request outstanding");
    end
  end

  initial begin
    #(timeout_cycles * clk_period);
    report_failure("Watchdog timeout, the test sequence did not complete in time");
  end

  initial begin
    logic [`SOC_DATA_W-1:0] data_r;
    logic [`SOC_BE_W-1:0]   be_r;
    logic                   we_r;
    int unsigned            idx_r;
    clk          = 1'b0;
    rst_n        = 1'b0;
    ndmreset     = 1'b0;
    bus_req      = '0;
    dbg_jtag_req = 1'b1;
    dbg_dmi_req  = 1'b1;
    dbg_ctrl     = '{en: 1'b1, src: DBG_SRC_JTAG};
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Hold-off with both sources high, then every gating combination
    repeat (`SOC_DBG_DELAY - 1) @(posedge clk);
    @(negedge clk);
    check_dbg_req(1'b0, dbg_req_core);
    @(posedge clk);
    @(negedge clk);
    check_dbg_req(1'b1, dbg_req_core);
    for (int i = 0; i < 16; i++) begin
      drive_dbg(i[0], i[1], i[2], i[3]);
    end

    // RAM full writes, partial writes, read-back
    for (int i = 0; i < num_words; i++) begin
      words[i] = ram_idx_w'(rand_bits(ram_idx_w));
      data_r   = rand_bits(64);
      bus_access(1'b1, ram_addr(words[i]), '1, data_r, 1'b1);
    end
    for (int i = 0; i < num_rand_wr; i++) begin
      idx_r  = int'(rand_bits(4));
      be_r   = 8'(rand_bits(8));
      data_r = rand_bits(64);
      bus_access(1'b1, ram_addr(words[idx_r]), be_r, data_r, 1'b1);
    end
    for (int i = 0; i < num_words; i++) begin
      bus_access(1'b0, ram_addr(words[i]), '0, '0, 1'b1);
    end

    // ROM reads
    for (int i = 0; i < num_rom; i++) begin
      idx_r = int'(rand_bits(rom_idx_w));
      bus_access(1'b0, rom_addr(idx_r), '0, '0, 1'b1);
    end

    // Error target, then ROM writes and their read-back
    for (int i = 0; i < num_gpio; i++) begin
      we_r   = 1'(rand_bits(1));
      idx_r  = int'(rand_bits(gpio_idx_w));
      data_r = rand_bits(64);
      bus_access(we_r, `SOC_GPIO_BASE + idx_r * `SOC_BE_W, '1, data_r, 1'b1);
    end
    for (int i = 0; i < num_unmapped; i++) begin
      bus_access(1'(i % 2), unmapped[i], '1, '1, 1'b1);
    end
    for (int i = 0; i < num_rom_wr; i++) begin
      rom_idx[i] = rom_idx_w'(rand_bits(rom_idx_w));
      data_r     = rand_bits(64);
      bus_access(1'b1, rom_addr(rom_idx[i]), '1, data_r, 1'b1);
    end
    for (int i = 0; i < num_rom_wr; i++) begin
      bus_access(1'b0, rom_addr(rom_idx[i]), '0, '0, 1'b1);
    end

    // Mixed burst in consecutive cycles
    for (int i = 0; i < num_b2b; i++) begin
      idx_r  = int'(rand_bits(4));
      be_r   = 8'(rand_bits(8));
      data_r = rand_bits(64);
      case (i % 4)
        0: bus_access(1'b0, ram_addr(words[idx_r]), '0, '0, 1'b1);
        1: bus_access(1'b0, rom_addr(int'(data_r[rom_idx_w-1:0])), '0, '0, 1'b1);
        2: bus_access(1'b1, ram_addr(words[idx_r]), be_r, data_r, 1'b1);
        default: bus_access(1'b1, unmapped[idx_r % num_unmapped], be_r, data_r, 1'b1);
      endcase
    end
    bus_idle();

    // Debug module reset drops requests and keeps RAM and hold-off
    drive_dbg(1'b1, 1'b0, 1'b0, 1'b1);
    drive_ndmreset(1'b1);
    @(negedge clk);
    check_core_rst(1'b0, core_rst_n);
    check_dbg_req(1'b1, dbg_req_core);
    for (int i = 0; i < num_ndm; i++) begin
      data_r = rand_bits(64);
      bus_access(1'b1, ram_addr(words[i]), '1, data_r, 1'b0);
    end
    drive_ndmreset(1'b0);
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_core_rst(1'b1, core_rst_n);
    for (int i = 0; i < num_words; i++) begin
      bus_access(1'b0, ram_addr(words[i]), '0, '0, 1'b1);
    end
    bus_idle();

    while (due_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(posedge clk);
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/soc_harness_top.sv */
// Harness top: bus router with ROM, RAM and error target plus reset and debug control
// The bus has no back-pressure, every response must be taken
`timescale 1ns/1ps
`default_nettype none

`include "soc_macros.svh"

module soc_harness_top import soc_bus_pkg::*, soc_dbg_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      ndmreset_i,
  input  bus_req_t  bus_req_i,
  output bus_rsp_t  bus_rsp_o,
  input  logic      dbg_jtag_req_i,
  input  logic      dbg_dmi_req_i,
  input  dbg_ctrl_t dbg_ctrl_i,
  output logic      core_rst_no,
  output logic      dbg_req_core_o
);

  localparam int unsigned RamWordW = $clog2(`SOC_RAM_WORDS);
  localparam int unsigned RomWordW = $clog2(`SOC_ROM_WORDS);

  logic                   rom_req;
  logic                   ram_req;
  logic                   ram_we;
  logic [RamWordW-1:0]    word;
  logic [`SOC_BE_W-1:0]   be;
  logic [`SOC_DATA_W-1:0] wdata;
  logic [`SOC_DATA_W-1:0] rom_rdata;
  logic [`SOC_DATA_W-1:0] ram_rdata;

  // ------------------------------
  // Reset and debug
  // ------------------------------
  soc_reset_debug_ctrl i_reset_debug_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .ndmreset_i     ( ndmreset_i     ),
    .dbg_jtag_req_i ( dbg_jtag_req_i ),
    .dbg_dmi_req_i  ( dbg_dmi_req_i  ),
    .dbg_ctrl_i     ( dbg_ctrl_i     ),
    .core_rst_no    ( core_rst_no    ),
    .dbg_req_core_o ( dbg_req_core_o )
  );

  // ------------------------------
  // Bus and targets
  // ------------------------------
  // Router runs on the core reset
  soc_bus_router i_bus_router (
    .clk_i       ( clk_i       ),
    .rst_ni      ( core_rst_no ),
    .bus_req_i   ( bus_req_i   ),
    .bus_rsp_o   ( bus_rsp_o   ),
    .rom_req_o   ( rom_req     ),
    .ram_req_o   ( ram_req     ),
    .ram_we_o    ( ram_we      ),
    .word_o      ( word        ),
    .be_o        ( be          ),
    .wdata_o     ( wdata       ),
    .rom_rdata_i ( rom_rdata   ),
    .ram_rdata_i ( ram_rdata   )
  );

  soc_ram i_ram (
    .clk_i     ( clk_i     ),
    .ram_req_i ( ram_req   ),
    .ram_we_i  ( ram_we    ),
    .word_i    ( word      ),
    .be_i      ( be        ),
    .wdata_i   ( wdata     ),
    .rdata_o   ( ram_rdata )
  );

  // ROM is smaller, takes the low index bits only
  soc_boot_rom i_boot_rom (
    .clk_i     ( clk_i                ),
    .rom_req_i ( rom_req              ),
    .word_i    ( word[RomWordW-1:0]   ),
    .rdata_o   ( rom_rdata            )
  );

endmodule

`default_nettype wire

/* hw/soc_reset_debug_ctrl.sv */
// Core reset generation and gated debug request for the core
// Hold-off counter restarts on power-on reset only, not on ndmreset
`timescale 1ns/1ps
`default_nettype none

`include "soc_macros.svh"

module soc_reset_debug_ctrl import soc_dbg_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      ndmreset_i,
  input  logic      dbg_jtag_req_i,
  input  logic      dbg_dmi_req_i,
  input  dbg_ctrl_t dbg_ctrl_i,
  output logic      core_rst_no,
  output logic      dbg_req_core_o
);

  localparam int unsigned CntW = $clog2(`SOC_DBG_DELAY + 1);

  logic            rst_comb_n;
  logic [1:0]      sync_q;
  logic [CntW-1:0] del_cnt_q;
  logic            dbg_req_sel;

  // ------------------------------
  // Core reset
  // ------------------------------
  // Power-on or debug module reset, asserted at once
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  // Two flops so that release is clean w.r.t. clk_i
  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign core_rst_no = sync_q[1];

  // ------------------------------
  // Debug hold-off
  // ------------------------------
  // Gives boot code time to run before the first halt
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      del_cnt_q <= CntW'(`SOC_DBG_DELAY);
    end else if (del_cnt_q != '0) begin
      del_cnt_q <= del_cnt_q - 1'b1;
    end
  end

  // Source select
  assign dbg_req_sel = (dbg_ctrl_i.src == DBG_SRC_JTAG) ? dbg_jtag_req_i : dbg_dmi_req_i;

  // Blocked during hold-off or when debug is off
  assign dbg_req_core_o = (del_cnt_q != '0) ? 1'b0 :
                          (!dbg_ctrl_i.en)  ? 1'b0 : dbg_req_sel;

endmodule

`default_nettype wire

/* hw/soc_bus_router.sv */
// Address decoder and response path with a fixed latency of one cycle
// No back-pressure; GPIO, unmapped addresses and ROM writes answer with err
`timescale 1ns/1ps
`default_nettype none

`include "soc_macros.svh"

module soc_bus_router import soc_bus_pkg::*; (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  bus_req_t                             bus_req_i,
  output bus_rsp_t                             bus_rsp_o,
  output logic                                 rom_req_o,
  output logic                                 ram_req_o,
  output logic                                 ram_we_o,
  output logic [$clog2(`SOC_RAM_WORDS)-1:0]    word_o,
  output logic [`SOC_BE_W-1:0]                 be_o,
  output logic [`SOC_DATA_W-1:0]               wdata_o,
  input  logic [`SOC_DATA_W-1:0]               rom_rdata_i,
  input  logic [`SOC_DATA_W-1:0]               ram_rdata_i
);

  localparam int unsigned ByteOff = $clog2(`SOC_BE_W);
  localparam int unsigned WordW   = $clog2(`SOC_RAM_WORDS);

  // Last byte address of each window
  localparam logic [`SOC_ADDR_W-1:0] RomLast  =
      `SOC_ROM_BASE + `SOC_ROM_WORDS * `SOC_BE_W - 1;
  localparam logic [`SOC_ADDR_W-1:0] RamLast  =
      `SOC_RAM_BASE + `SOC_RAM_WORDS * `SOC_BE_W - 1;
  localparam logic [`SOC_ADDR_W-1:0] GpioLast = `SOC_GPIO_BASE + `SOC_GPIO_LEN - 1;

  region_e region;
  logic    accept;
  logic    err;

  region_e region_q;
  logic    we_q;
  logic    err_q;
  logic    valid_q;

  // ------------------------------
  // Decode
  // ------------------------------
  always_comb begin
    if (bus_req_i.addr >= `SOC_ROM_BASE && bus_req_i.addr <= RomLast) begin
      region = REGION_ROM;
    end else if (bus_req_i.addr >= `SOC_RAM_BASE && bus_req_i.addr <= RamLast) begin
      region = REGION_RAM;
    end else if (bus_req_i.addr >= `SOC_GPIO_BASE && bus_req_i.addr <= GpioLast) begin
      region = REGION_GPIO;
    end else begin
      region = REGION_NONE;
    end
  end

  // Nothing is accepted while the core is held in reset
  assign accept = bus_req_i.req & rst_ni;
  assign err    = (region == REGION_GPIO) || (region == REGION_NONE) ||
                  (region == REGION_ROM && bus_req_i.we);

  // Target strobes, ROM write goes nowhere
  assign rom_req_o = accept && (region == REGION_ROM) && !bus_req_i.we;
  assign ram_req_o = accept && (region == REGION_RAM);
  assign ram_we_o  = bus_req_i.we;

  // Bases are size-aligned so the low address bits index both memories
  assign word_o  = bus_req_i.addr[ByteOff +: WordW];
  assign be_o    = bus_req_i.be;
  assign wdata_o = bus_req_i.wdata;

  // ------------------------------
  // Response stage
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= 1'b0;
      err_q    <= 1'b0;
      we_q     <= 1'b0;
      region_q <= REGION_NONE;
    end else begin
      valid_q  <= accept;
      err_q    <= accept & err;
      we_q     <= bus_req_i.we;
      region_q <= region;
    end
  end

  always_comb begin
    bus_rsp_o        = '0;
    bus_rsp_o.rvalid = valid_q;
    bus_rsp_o.err    = err_q;
    if (valid_q && !we_q && !err_q) begin
      case (region_q)
        REGION_ROM: bus_rsp_o.rdata = rom_rdata_i;
        REGION_RAM: bus_rsp_o.rdata = ram_rdata_i;
        default:    bus_rsp_o.rdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/soc_ram.sv */
// Single-port RAM with byte enables, one access per cycle
// Contents are not initialised and survive every reset
`timescale 1ns/1ps
`default_nettype none

`include "soc_macros.svh"

module soc_ram (
  input  logic                                 clk_i,
  input  logic                                 ram_req_i,
  input  logic                                 ram_we_i,
  input  logic [$clog2(`SOC_RAM_WORDS)-1:0]    word_i,
  input  logic [`SOC_BE_W-1:0]                 be_i,
  input  logic [`SOC_DATA_W-1:0]               wdata_i,
  output logic [`SOC_DATA_W-1:0]               rdata_o
);

  logic [`SOC_DATA_W-1:0] mem [`SOC_RAM_WORDS];

  // ------------------------------
  // Write port
  // ------------------------------
  // Only enabled bytes are touched
  always_ff @(posedge clk_i) begin
    if (ram_req_i && ram_we_i) begin
      for (int b = 0; b < `SOC_BE_W; b++) begin
        if (be_i[b]) begin
          mem[word_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // ------------------------------
  // Read port
  // ------------------------------
  // Registered read, output holds across writes
  always_ff @(posedge clk_i) begin
    if (ram_req_i && !ram_we_i) begin
      rdata_o <= mem[word_i];
    end
  end

endmodule

`default_nettype wire

/* hw/soc_boot_rom.sv */
// Boot ROM with generated contents, one registered read per request
// Word i holds i in the upper half and ~i in the lower half
`timescale 1ns/1ps
`default_nettype none

`include "soc_macros.svh"

module soc_boot_rom (
  input  logic                                 clk_i,
  input  logic                                 rom_req_i,
  input  logic [$clog2(`SOC_ROM_WORDS)-1:0]    word_i,
  output logic [`SOC_DATA_W-1:0]               rdata_o
);

  localparam int unsigned HalfW = `SOC_DATA_W / 2;

  logic [HalfW-1:0] index_ext;

  // Zero-extended index forms both halves of the word
  assign index_ext = HalfW'(word_i);

  // ------------------------------
  // Read port
  // ------------------------------
  // Output holds the last word read between requests
  always_ff @(posedge clk_i) begin
    if (rom_req_i) begin
      rdata_o <= {index_ext, ~index_ext};
    end
  end

endmodule

`default_nettype wire

/* hw/soc_dbg_pkg.sv */
// Debug source selection and control types
`default_nettype none

package soc_dbg_pkg;

  // Which debug transport drives the core request
  typedef enum logic {
    DBG_SRC_DMI  = 1'b0,
    DBG_SRC_JTAG = 1'b1
  } dbg_src_e;

  // Static debug configuration, held as levels
  typedef struct packed {
    logic     en;
    dbg_src_e src;
  } dbg_ctrl_t;

endpackage

`default_nettype wire

/* hw/soc_bus_pkg.sv */
// Types of the single-cycle memory bus and its decoded target regions
`default_nettype none

`include "soc_macros.svh"

package soc_bus_pkg;

  // Request from the core side, sampled every cycle
  typedef struct packed {
    logic                   req;
    logic                   we;
    logic [`SOC_ADDR_W-1:0] addr;
    logic [`SOC_BE_W-1:0]   be;
    logic [`SOC_DATA_W-1:0] wdata;
  } bus_req_t;

  // Response one cycle after the request
  // rdata is zero on writes and errors
  typedef struct packed {
    logic                   rvalid;
    logic                   err;
    logic [`SOC_DATA_W-1:0] rdata;
  } bus_rsp_t;

  // Decoded target of an access
  typedef enum logic [1:0] {
    REGION_ROM  = 2'd0,
    REGION_RAM  = 2'd1,
    REGION_GPIO = 2'd2,
    REGION_NONE = 2'd3
  } region_e;

endpackage

`default_nettype wire

/* hw/soc_macros.svh */
// Bus widths, address map and debug timing shared by RTL and testbench
// ROM and RAM bases must be aligned to their region size
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// ------------------------------
// Bus widths
// ------------------------------
`define SOC_ADDR_W 32
`define SOC_DATA_W 64
`define SOC_BE_W (`SOC_DATA_W / 8)

// ------------------------------
// Address map
// ------------------------------
`define SOC_ROM_BASE 32'h0001_0000
`define SOC_ROM_WORDS 512
`define SOC_RAM_BASE 32'h8000_0000
`define SOC_RAM_WORDS 1024
`define SOC_GPIO_BASE 32'h4000_0000
`define SOC_GPIO_LEN 32'h0000_1000

// Debug hold-off after power-on reset, in cycles
`define SOC_DBG_DELAY 20

`endif
